/* decoder_ctrl_pkg.sv */
package decoder_ctrl_pkg;

    // encoded widths of the stage and the command opcode
    localparam int STAGE_WIDTH = 3;
    localparam int CMD_OP_WIDTH = 3;

    // zero pad so the link word keeps its old address width plus three
    localparam int RESERVED_WIDTH = 8;

    // round statistics
    localparam int ITERATION_WIDTH = 8;
    localparam int CYCLE_WIDTH = 32;

    // decoder stages, one per phase of a union-find round
    typedef enum logic [STAGE_WIDTH-1:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_SPREAD_CLUSTER      = 3'd1,
        STAGE_GROW_BOUNDARY       = 3'd2,
        STAGE_SYNC_IS_ODD_CLUSTER = 3'd3,
        STAGE_RESULT_CALCULATING  = 3'd4,
        STAGE_MEASUREMENT_LOADING = 3'd5
    } stage_e;

    // opcodes seen by the downstream processing units
    typedef enum logic [CMD_OP_WIDTH-1:0] {
        CMD_NONE    = 3'd0,
        CMD_ADVANCE = 3'd1,
        CMD_FINISH  = 3'd2,
        CMD_ABORT   = 3'd3
    } cmd_op_e;

    // link word, opcode sits in the low bits
    typedef struct packed {
        logic [RESERVED_WIDTH-1:0] reserved;
        cmd_op_e                   op;
    } stage_cmd_t;

endpackage

/* cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int FIFO_DEPTH = 16,
    parameter type item_t = logic [7:0]
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  item_t cmd_in,
    input  logic  pop,
    output logic  full,
    output item_t head,
    output logic  head_valid
);

    localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(FIFO_DEPTH - 1);
    localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(FIFO_DEPTH);

    item_t                  mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    // writer keeps off a full FIFO, so push is taken as is
    assign do_push = push;
    assign do_pop = pop && head_valid;

    assign full = (count == FULL_COUNT);
    assign head_valid = (count != '0);
    // fall-through head, no read latency
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= cmd_in;
        end
    end

    // pointers wrap by hand so any depth works
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* link_transmitter.sv */
`timescale 1ns/1ps

module link_transmitter
    import decoder_ctrl_pkg::*;
#(
    parameter int LINK_CREDITS = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  stage_cmd_t head,
    input  logic       head_valid,
    input  logic       link_credit,
    output logic       pop,
    output logic       link_valid,
    output stage_cmd_t link_cmd
);

    localparam int CREDIT_WIDTH = $clog2(LINK_CREDITS + 1);
    localparam logic [CREDIT_WIDTH-1:0] CREDIT_INIT = CREDIT_WIDTH'(LINK_CREDITS);

    logic [CREDIT_WIDTH-1:0] credits;
    logic                    credit_free;

    // word on the link still holds its credit until this cycle ends
    assign credit_free = (credits > CREDIT_WIDTH'(link_valid));
    // at most one word per cycle
    assign pop = head_valid && credit_free;

    // spent on each link beat, returned on each credit pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CREDIT_INIT;
        end else begin
            case ({link_valid, link_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // popped word goes out on the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            link_valid <= 1'b0;
        end else begin
            link_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            link_cmd <= head;
        end
    end

endmodule

/* stage_sequencer.sv */
`timescale 1ns/1ps

module stage_sequencer
    import decoder_ctrl_pkg::*;
#(
    parameter int SPREAD_DELAY = 9,
    parameter int SYNC_DELAY = 9,
    parameter int GROW_DELAY = 3,
    parameter int MESSAGE_FLYING_DELAY = 3
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       new_round_start,
    input  logic       downstream_has_message_flying,
    input  logic       downstream_has_odd_clusters,
    input  logic       full,
    input  logic       stall_timeout,
    output logic       push,
    output stage_cmd_t cmd_in,
    output stage_e     stage,
    output logic       iteration_done
);

    // one counter serves every timed stage, so size it for the longest
    localparam int MAX_DELAY = (SPREAD_DELAY > SYNC_DELAY) ?
        ((SPREAD_DELAY > GROW_DELAY) ? SPREAD_DELAY : GROW_DELAY) :
        ((SYNC_DELAY > GROW_DELAY) ? SYNC_DELAY : GROW_DELAY);
    localparam int DELAY_WIDTH = $clog2(MAX_DELAY + 1);
    localparam logic [DELAY_WIDTH-1:0] SPREAD_LAST = DELAY_WIDTH'(SPREAD_DELAY);
    localparam logic [DELAY_WIDTH-1:0] SYNC_LAST = DELAY_WIDTH'(SYNC_DELAY);
    localparam logic [DELAY_WIDTH-1:0] GROW_LAST = DELAY_WIDTH'(GROW_DELAY);

    stage_e                     stage_next;
    cmd_op_e                    cmd_op;
    logic [DELAY_WIDTH-1:0]     delay_count;
    logic [DELAY_WIDTH-1:0]     delay_target;
    logic                       delay_reached;
    logic [MESSAGE_FLYING_DELAY-1:0] flying_window;
    logic                       messages_flying;

    // recent history of the downstream flag
    always_ff @(posedge clk) begin
        if (reset) begin
            flying_window <= '0;
        end else begin
            for (int i = MESSAGE_FLYING_DELAY - 1; i > 0; i--) begin
                flying_window[i] <= flying_window[i-1];
            end
            flying_window[0] <= downstream_has_message_flying;
        end
    end

    // still flying if seen anywhere in the window
    assign messages_flying = |flying_window;

    // minimum dwell of the current stage
    always_comb begin
        case (stage)
            STAGE_SPREAD_CLUSTER:      delay_target = SPREAD_LAST;
            STAGE_SYNC_IS_ODD_CLUSTER: delay_target = SYNC_LAST;
            STAGE_GROW_BOUNDARY:       delay_target = GROW_LAST;
            default:                   delay_target = '0;
        endcase
    end

    assign delay_reached = (delay_count >= delay_target);

    // transitions and the command issued with each of them
    // a full FIFO freezes the stage, nothing is pushed then
    always_comb begin
        stage_next = stage;
        push = 1'b0;
        cmd_op = CMD_NONE;
        iteration_done = 1'b0;
        case (stage)
            STAGE_IDLE: begin
                if (new_round_start && !full) begin
                    push = 1'b1;
                    cmd_op = CMD_ADVANCE;
                    stage_next = STAGE_MEASUREMENT_LOADING;
                end
            end
            // single cycle, syndrome comes from an external buffer
            STAGE_MEASUREMENT_LOADING: begin
                stage_next = STAGE_SPREAD_CLUSTER;
            end
            STAGE_SPREAD_CLUSTER: begin
                if (delay_reached && !full) begin
                    if (!messages_flying) begin
                        push = 1'b1;
                        cmd_op = CMD_ADVANCE;
                        stage_next = STAGE_SYNC_IS_ODD_CLUSTER;
                    end else if (stall_timeout) begin
                        push = 1'b1;
                        cmd_op = CMD_ABORT;
                        stage_next = STAGE_RESULT_CALCULATING;
                    end
                end
            end
            STAGE_SYNC_IS_ODD_CLUSTER: begin
                if (delay_reached && !full) begin
                    if (!messages_flying) begin
                        push = 1'b1;
                        iteration_done = 1'b1;
                        // odd clusters left means another grow pass
                        if (downstream_has_odd_clusters) begin
                            cmd_op = CMD_ADVANCE;
                            stage_next = STAGE_GROW_BOUNDARY;
                        end else begin
                            cmd_op = CMD_FINISH;
                            stage_next = STAGE_RESULT_CALCULATING;
                        end
                    end else if (stall_timeout) begin
                        push = 1'b1;
                        cmd_op = CMD_ABORT;
                        stage_next = STAGE_RESULT_CALCULATING;
                    end
                end
            end
            STAGE_GROW_BOUNDARY: begin
                if (delay_reached && !full) begin
                    push = 1'b1;
                    cmd_op = CMD_ADVANCE;
                    stage_next = STAGE_SPREAD_CLUSTER;
                end
            end
            STAGE_RESULT_CALCULATING: begin
                stage_next = STAGE_IDLE;
            end
            default: begin
                stage_next = STAGE_IDLE;
            end
        endcase
    end

    assign cmd_in = '{reserved: '0, op: cmd_op};

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
            delay_count <= '0;
        end else begin
            stage <= stage_next;
            // restart the dwell count on every stage change
            if (stage_next != stage) begin
                delay_count <= '0;
            end else if (!delay_reached) begin
                delay_count <= delay_count + 1'b1;
            end
        end
    end

endmodule

/* round_monitor.sv */
`timescale 1ns/1ps

module round_monitor
    import decoder_ctrl_pkg::*;
#(
    parameter int DEADLOCK_THRESHOLD = 270
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       new_round_start,
    input  stage_e                     stage,
    input  logic                       iteration_done,
    output logic                       stall_timeout,
    output logic                       busy,
    output logic [ITERATION_WIDTH-1:0] iteration_counter,
    output logic [CYCLE_WIDTH-1:0]     cycle_counter,
    output logic                       deadlock
);

    // room for one count past the threshold
    localparam int TIMER_WIDTH = $clog2(DEADLOCK_THRESHOLD + 2);
    localparam logic [TIMER_WIDTH-1:0] TIMER_LIMIT = TIMER_WIDTH'(DEADLOCK_THRESHOLD);

    logic [TIMER_WIDTH-1:0] stall_timer;

    assign stall_timeout = (stall_timer > TIMER_LIMIT);
    assign busy = (stage != STAGE_IDLE);

    // only the message-driven stages can hang
    // timer saturates once the limit is passed
    always_ff @(posedge clk) begin
        if (reset) begin
            stall_timer <= '0;
        end else begin
            case (stage)
                STAGE_IDLE, STAGE_MEASUREMENT_LOADING, STAGE_GROW_BOUNDARY: begin
                    stall_timer <= '0;
                end
                STAGE_SPREAD_CLUSTER, STAGE_SYNC_IS_ODD_CLUSTER: begin
                    if (!stall_timeout) begin
                        stall_timer <= stall_timer + 1'b1;
                    end
                end
                default: begin
                    stall_timer <= stall_timer;
                end
            endcase
        end
    end

    // sticky until the next round begins
    always_ff @(posedge clk) begin
        if (reset) begin
            deadlock <= 1'b0;
        end else if (new_round_start) begin
            deadlock <= 1'b0;
        end else if (stall_timeout) begin
            deadlock <= 1'b1;
        end
    end

    // per-round statistics, restarted in loading
    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_counter <= '0;
            cycle_counter <= '0;
        end else begin
            if (stage == STAGE_MEASUREMENT_LOADING) begin
                iteration_counter <= '0;
            end else if (iteration_done) begin
                iteration_counter <= iteration_counter + 1'b1;
            end
            // loading is the first busy cycle
            if (stage == STAGE_MEASUREMENT_LOADING) begin
                cycle_counter <= CYCLE_WIDTH'(1);
            end else if (busy) begin
                cycle_counter <= cycle_counter + 1'b1;
            end
        end
    end

endmodule

/* stage_controller_top.sv */
`timescale 1ns/1ps

module stage_controller_top
    import decoder_ctrl_pkg::*;
#(
    parameter int CODE_DISTANCE_X = 3,
    parameter int CODE_DISTANCE_Z = 3,
    parameter int SPREAD_DELAY = 9,
    parameter int SYNC_DELAY = 9,
    parameter int GROW_DELAY = 3,
    parameter int MESSAGE_FLYING_DELAY = 3,
    // volume of the decoding graph, times ten
    parameter int DEADLOCK_THRESHOLD = CODE_DISTANCE_X * CODE_DISTANCE_Z *
        ((CODE_DISTANCE_X > CODE_DISTANCE_Z) ? CODE_DISTANCE_X : CODE_DISTANCE_Z) * 10,
    parameter int FIFO_DEPTH = 16,
    parameter int LINK_CREDITS = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       new_round_start,
    input  logic                       downstream_has_message_flying,
    input  logic                       downstream_has_odd_clusters,
    input  logic                       link_credit,
    output logic                       link_valid,
    output stage_cmd_t                 link_cmd,
    output logic                       busy,
    output logic [ITERATION_WIDTH-1:0] iteration_counter,
    output logic [CYCLE_WIDTH-1:0]     cycle_counter,
    output logic                       deadlock
);

    logic       push;
    stage_cmd_t cmd_in;
    logic       full;
    stage_cmd_t head;
    logic       head_valid;
    logic       pop;
    stage_e     stage;
    logic       iteration_done;
    logic       stall_timeout;

    // sequencer -> fifo -> transmitter, monitor on the side
    stage_sequencer #(
        .SPREAD_DELAY(SPREAD_DELAY),
        .SYNC_DELAY(SYNC_DELAY),
        .GROW_DELAY(GROW_DELAY),
        .MESSAGE_FLYING_DELAY(MESSAGE_FLYING_DELAY)
    ) u_sequencer (
        .clk(clk),
        .reset(reset),
        .new_round_start(new_round_start),
        .downstream_has_message_flying(downstream_has_message_flying),
        .downstream_has_odd_clusters(downstream_has_odd_clusters),
        .full(full),
        .stall_timeout(stall_timeout),
        .push(push),
        .cmd_in(cmd_in),
        .stage(stage),
        .iteration_done(iteration_done)
    );

    round_monitor #(
        .DEADLOCK_THRESHOLD(DEADLOCK_THRESHOLD)
    ) u_monitor (
        .clk(clk),
        .reset(reset),
        .new_round_start(new_round_start),
        .stage(stage),
        .iteration_done(iteration_done),
        .stall_timeout(stall_timeout),
        .busy(busy),
        .iteration_counter(iteration_counter),
        .cycle_counter(cycle_counter),
        .deadlock(deadlock)
    );

    cmd_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .item_t(stage_cmd_t)
    ) u_fifo (
        .clk(clk),
        .reset(reset),
        .push(push),
        .cmd_in(cmd_in),
        .pop(pop),
        .full(full),
        .head(head),
        .head_valid(head_valid)
    );

    link_transmitter #(
        .LINK_CREDITS(LINK_CREDITS)
    ) u_transmitter (
        .clk(clk),
        .reset(reset),
        .head(head),
        .head_valid(head_valid),
        .link_credit(link_credit),
        .pop(pop),
        .link_valid(link_valid),
        .link_cmd(link_cmd)
    );

endmodule

/* stage_controller_assert.sv */
`timescale 1ns/1ps

module stage_controller_assert #(
    parameter int LINK_CREDITS = 4,
    parameter int CREDIT_WIDTH = $clog2(LINK_CREDITS + 1)
) (
    input logic                    clk,
    input logic                    reset,
    input logic                    link_valid,
    input logic                    push,
    input logic                    full,
    input logic [CREDIT_WIDTH-1:0] credits
);

    // read back by the testbench at the end
    int failures = 0;

    // every link beat spends a credit held before it
    a_credit_before_send: assert property (@(posedge clk) disable iff (reset)
        link_valid |-> (credits != '0))
    else begin
        $error("link word sent without a credit");
        failures = failures + 1;
    end

    // returned credits never pile up past the pool
    a_credit_limit: assert property (@(posedge clk) disable iff (reset)
        credits <= CREDIT_WIDTH'(LINK_CREDITS))
    else begin
        $error("credit count above the link credit pool");
        failures = failures + 1;
    end

    // FIFO takes every push, writer must hold off when full
    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        !(push && full))
    else begin
        $error("command pushed into a full FIFO");
        failures = failures + 1;
    end

endmodule

bind stage_controller_top stage_controller_assert #(
    .LINK_CREDITS(LINK_CREDITS)
) u_assert (
    .clk(clk),
    .reset(reset),
    .link_valid(link_valid),
    .push(push),
    .full(full),
    .credits(u_transmitter.credits)
);

/* tb_stage_controller.sv */
`timescale 1ns/1ps

module tb_stage_controller
    import decoder_ctrl_pkg::*;
();

    localparam int LINK_CREDITS = 2;
    localparam int WAIT_LIMIT = 400;

    // wait conditions
    localparam int WAIT_SPREAD = 0;
    localparam int WAIT_DEADLOCK = 1;
    localparam int WAIT_FULL = 2;
    localparam int WAIT_DRAINED = 3;

    logic                       clk = 1'b0;
    logic                       reset = 1'b1;
    logic                       new_round_start = 1'b0;
    logic                       downstream_has_message_flying = 1'b0;
    logic                       downstream_has_odd_clusters = 1'b0;
    logic                       link_credit = 1'b0;
    logic                       link_valid;
    stage_cmd_t                 link_cmd;
    logic                       busy;
    logic [ITERATION_WIDTH-1:0] iteration_counter;
    logic [CYCLE_WIDTH-1:0]     cycle_counter;
    logic                       deadlock;

    // downstream model state
    cmd_op_e     rx_ops[$];
    cmd_op_e     expected_ops[$];
    int          sent_words = 0;
    int          returned_credits = 0;
    int          credit_gap = 0;
    int          busy_cycles = 0;
    logic        credit_hold = 1'b0;
    int          odd_syncs = 0;
    logic [31:0] rng_state = 32'd79555;

    // per-test bookkeeping
    string test_name;
    int    rx_base = 0;
    int    busy_base = 0;
    int    test_errors = 0;
    int    total_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    bit    timed_out = 1'b0;

    always #4 clk = ~clk;

    stage_controller_top #(
        .SPREAD_DELAY(4),
        .SYNC_DELAY(3),
        .GROW_DELAY(2),
        .MESSAGE_FLYING_DELAY(3),
        .DEADLOCK_THRESHOLD(40),
        .FIFO_DEPTH(4),
        .LINK_CREDITS(LINK_CREDITS)
    ) u_dut (
        .clk(clk),
        .reset(reset),
        .new_round_start(new_round_start),
        .downstream_has_message_flying(downstream_has_message_flying),
        .downstream_has_odd_clusters(downstream_has_odd_clusters),
        .link_credit(link_credit),
        .link_valid(link_valid),
        .link_cmd(link_cmd),
        .busy(busy),
        .iteration_counter(iteration_counter),
        .cycle_counter(cycle_counter),
        .deadlock(deadlock)
    );

    // xorshift32 for the credit return gaps
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // link receiver, values from the cycle that just ended
    always @(posedge clk) begin
        if (!reset) begin
            if (link_valid) begin
                rx_ops.push_back(link_cmd.op);
                sent_words = sent_words + 1;
                // reserved bits stay zero on the link
                assert (link_cmd.reserved == '0) else begin
                    $display("MISMATCH %s: reserved field expected 0 actual %0d",
                        test_name, link_cmd.reserved);
                    test_errors++;
                end
            end
            if (busy) begin
                busy_cycles = busy_cycles + 1;
            end
        end
    end

    // credit return and odd cluster report
    // one low cycle at least between two credit pulses
    always @(negedge clk) begin
        downstream_has_odd_clusters <= (int'(iteration_counter) < odd_syncs);
        if (credit_gap > 0) begin
            link_credit <= 1'b0;
            credit_gap <= credit_gap - 1;
        end else if (!credit_hold && sent_words != returned_credits) begin
            link_credit <= 1'b1;
            returned_credits <= returned_credits + 1;
            credit_gap <= 1 + int'(next_random() % 32'd3);
        end else begin
            link_credit <= 1'b0;
        end
    end

    function automatic bit condition_met(input int kind);
        case (kind)
            WAIT_SPREAD:   return u_dut.stage == STAGE_SPREAD_CLUSTER;
            WAIT_DEADLOCK: return deadlock;
            WAIT_FULL:     return u_dut.full;
            // round over and every word and credit accounted for
            default: return !busy && !link_valid && !link_credit && !u_dut.head_valid &&
                (sent_words == returned_credits);
        endcase
    endfunction

    task automatic wait_for(input int kind, input string what);
        int cycles;
        cycles = 0;
        while (!timed_out && !condition_met(kind)) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout in %s: %s did not happen within %0d cycles",
                    test_name, what, WAIT_LIMIT);
                timed_out = 1'b1;
                test_errors++;
            end
        end
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("MISMATCH %s: %s expected %0d actual %0d", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    // advance per stage change, finish after the last sync
    task automatic expect_round(input int odd);
        expected_ops.delete();
        expected_ops.push_back(CMD_ADVANCE);
        expected_ops.push_back(CMD_ADVANCE);
        for (int i = 0; i < 3 * odd; i++) begin
            expected_ops.push_back(CMD_ADVANCE);
        end
        expected_ops.push_back(CMD_FINISH);
    endtask

    task automatic check_ops();
        int received;
        received = rx_ops.size() - rx_base;
        check_value("command count", expected_ops.size(), received);
        foreach (expected_ops[i]) begin
            if (i < received) begin
                assert (rx_ops[rx_base + i] == expected_ops[i]) else begin
                    $display("MISMATCH %s: command %0d expected %s actual %s", test_name, i,
                        expected_ops[i].name(), rx_ops[rx_base + i].name());
                    test_errors++;
                end
            end
        end
    endtask

    // one-cycle pulse, called on a falling edge
    task automatic start_round();
        rx_base = rx_ops.size();
        busy_base = busy_cycles;
        new_round_start = 1'b1;
        @(negedge clk);
        new_round_start = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic test_reset();
        begin_test("reset");
        check_value("link_valid", 0, int'(link_valid));
        check_value("busy", 0, int'(busy));
        check_value("deadlock", 0, int'(deadlock));
        check_value("push", 0, int'(u_dut.push));
        check_value("pop", 0, int'(u_dut.pop));
        check_value("credits", LINK_CREDITS, int'(u_dut.u_transmitter.credits));
        end_test();
    endtask

    task automatic test_plain_round();
        begin_test("plain round");
        odd_syncs <= 0;
        start_round();
        wait_for(WAIT_DRAINED, "round end");
        expect_round(0);
        check_ops();
        check_value("iteration_counter", 1, int'(iteration_counter));
        check_value("cycle_counter", busy_cycles - busy_base, int'(cycle_counter));
        end_test();
    endtask

    task automatic test_odd_rounds();
        begin_test("odd clusters");
        odd_syncs <= 3;
        start_round();
        wait_for(WAIT_DRAINED, "round end");
        expect_round(3);
        check_ops();
        check_value("iteration_counter", 4, int'(iteration_counter));
        end_test();
    endtask

    task automatic test_message_window();
        begin_test("message window");
        odd_syncs <= 0;
        start_round();
        wait_for(WAIT_SPREAD, "spread stage");
        // two short bursts, each stretched by the window
        downstream_has_message_flying = 1'b1;
        repeat (2) @(negedge clk);
        downstream_has_message_flying = 1'b0;
        repeat (2) @(negedge clk);
        downstream_has_message_flying = 1'b1;
        @(negedge clk);
        downstream_has_message_flying = 1'b0;
        // last burst keeps spread open three more cycles
        repeat (3) @(negedge clk);
        check_value("stage held by window", int'(STAGE_SPREAD_CLUSTER), int'(u_dut.stage));
        @(negedge clk);
        check_value("stage after window", int'(STAGE_SYNC_IS_ODD_CLUSTER), int'(u_dut.stage));
        wait_for(WAIT_DRAINED, "round end");
        expect_round(0);
        check_ops();
        check_value("iteration_counter", 1, int'(iteration_counter));
        check_value("deadlock", 0, int'(deadlock));
        end_test();
    endtask

    task automatic test_deadlock();
        begin_test("deadlock");
        odd_syncs <= 0;
        start_round();
        wait_for(WAIT_SPREAD, "spread stage");
        downstream_has_message_flying = 1'b1;
        wait_for(WAIT_DEADLOCK, "deadlock flag");
        downstream_has_message_flying = 1'b0;
        wait_for(WAIT_DRAINED, "aborted round end");
        expected_ops.delete();
        expected_ops.push_back(CMD_ADVANCE);
        expected_ops.push_back(CMD_ABORT);
        check_ops();
        check_value("deadlock", 1, int'(deadlock));
        // next round clears the flag at its start edge
        start_round();
        check_value("deadlock after new round", 0, int'(deadlock));
        wait_for(WAIT_DRAINED, "recovery round end");
        expect_round(0);
        check_ops();
        end_test();
    endtask

    task automatic test_back_pressure();
        begin_test("back pressure");
        credit_hold <= 1'b1;
        odd_syncs <= 2;
        start_round();
        wait_for(WAIT_FULL, "full command FIFO");
        // the link should stay quiet here
        repeat (20) @(negedge clk);
        check_value("words sent without returns", LINK_CREDITS, rx_ops.size() - rx_base);
        check_value("busy while frozen", 1, int'(busy));
        credit_hold <= 1'b0;
        wait_for(WAIT_DRAINED, "round end after credits return");
        expect_round(2);
        check_ops();
        check_value("iteration_counter", 3, int'(iteration_counter));
        end_test();
    endtask

    initial begin
        int assert_failures;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        test_reset();
        if (!timed_out) test_plain_round();
        if (!timed_out) test_odd_rounds();
        if (!timed_out) test_message_window();
        if (!timed_out) test_deadlock();
        if (!timed_out) test_back_pressure();
        assert_failures = u_dut.u_assert.failures;
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
            tests_run, tests_failed, total_errors, assert_failures);
        if (total_errors == 0 && assert_failures == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sources.f */
decoder_ctrl_pkg.sv
cmd_fifo.sv
link_transmitter.sv
stage_sequencer.sv
round_monitor.sv
stage_controller_top.sv
stage_controller_assert.sv
tb_stage_controller.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_stage_controller
RTL_TOP    = stage_controller_top
FILE_LIST  = sources.f
OBJ_DIR    = obj_dir
PASS_TEXT  = Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILE_LIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)
